// ==== tb.f ====
source/rv_pkg.sv
source/inst_sram.sv
source/inst_fetch.sv
source/inst_decode.sv
source/alu_execute.sv
source/writeback_result.sv
source/core_top.sv
verif/tb_core.sv

// ==== Makefile ====
# Verilator build and run of the RV64I slice testbench

VERILATOR ?= verilator
TOP ?= tb_core
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_MSG ?= Everything OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out=$$(./$(BUILD_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(BUILD_DIR)

// ==== verif/tb_core.sv ====
module tb_core import rv_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int n_inst = 2 * mem_words;
	localparam int n_retire = 400;
	// generous per-retire budget plus program load and reset
	localparam int max_cycles = n_retire * 12 + mem_words + 20;

	logic clk;
	logic rst;
	logic run;
	logic mem_we;
	logic [mem_addr_w-1:0] mem_waddr;
	logic [xlen-1:0] mem_wdata;
	logic retire_valid;
	logic [pc_w-1:0] retire_pc;
	logic [reg_addr_w-1:0] retire_rd;
	logic [xlen-1:0] retire_value;
	logic retire_ready;

	logic [31:0] rng_state;
	logic [31:0] prog [n_inst];
	// reference register file where x0 stays zero
	logic [xlen-1:0] mregs [32];
	int cycles = 0;

	core_top core_top_i (
		.clk, .rst, .run, .mem_we, .mem_waddr, .mem_wdata,
		.retire_valid, .retire_pc, .retire_rd, .retire_value, .retire_ready
	);

	always #5 clk = ~clk;

	// xorshift32 step
	function automatic logic [31:0] draw_random();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// one random op or op-imm instruction over regs x0..x7
	function automatic logic [31:0] build_inst();
		logic [31:0] r;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [2:0] f3;
		logic alt;
		logic [11:0] imm;
		logic [6:0] f7;
		r = draw_random();
		rd = {2'b00, r[2:0]};
		rs1 = {2'b00, r[5:3]};
		rs2 = {2'b00, r[8:6]};
		f3 = r[11:9];
		alt = r[13];
		if (r[12]) begin
			// shifts carry a 6-bit shamt and srai sets imm bit 10
			if (f3 == f3_sll) begin
				imm = {6'b000000, r[31:26]};
			end else if (f3 == f3_sr) begin
				imm = {1'b0, alt, 4'b0000, r[31:26]};
			end else begin
				imm = r[25:14];
			end
			return {imm, rs1, f3, rd, opcode_op_imm};
		end
		// alt form exists only for sub and sra
		f7 = ((f3 == f3_add || f3 == f3_sr) && alt) ? 7'b0100000 : 7'b0000000;
		return {f7, rs2, rs1, f3, rd, opcode_op};
	endfunction

	// isa reference result decoded straight from the instruction bits
	function automatic logic [xlen-1:0] model_result(input logic [31:0] inst);
		logic is_reg;
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		logic signed [xlen-1:0] sa;
		logic signed [xlen-1:0] sb;
		logic [5:0] sh;
		logic [xlen-1:0] res;
		is_reg = inst[6:0] == opcode_op;
		a = mregs[inst[19:15]];
		b = is_reg ? mregs[inst[24:20]] : {{(xlen-12){inst[31]}}, inst[31:20]};
		sa = a;
		sb = b;
		sh = b[5:0];
		case (inst[14:12])
			3'b000: res = (is_reg && inst[30]) ? a - b : a + b;
			3'b001: res = a << sh;
			3'b010: res = {{(xlen-1){1'b0}}, sa < sb};
			3'b011: res = {{(xlen-1){1'b0}}, a < b};
			3'b100: res = a ^ b;
			3'b101: begin
				// arithmetic shift keeps the sign bit
				if (inst[30]) begin
					res = sa >>> sh;
				end else begin
					res = a >> sh;
				end
			end
			3'b110: res = a | b;
			default: res = a & b;
		endcase
		return res;
	endfunction

	task automatic check_value(input string name, input logic [xlen-1:0] got,
		input logic [xlen-1:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			$display("Something failed");
			$fatal(1);
		end
	endtask

	task automatic check_tag(input logic [pc_w-1:0] got_pc, input logic [pc_w-1:0] exp_pc,
		input logic [reg_addr_w-1:0] got_rd, input logic [reg_addr_w-1:0] exp_rd);
		if (got_pc !== exp_pc) begin
			$display("MISMATCH retire_pc got %h expected %h", got_pc, exp_pc);
			$display("Something failed");
			$fatal(1);
		end else if (got_rd !== exp_rd) begin
			$display("MISMATCH retire_rd got %h expected %h", got_rd, exp_rd);
			$display("Something failed");
			$fatal(1);
		end
	endtask

	// hang guard
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= max_cycles) begin
			$display("timeout: retirement stalled after %0d cycles", cycles);
			$display("Something failed");
			$fatal(1);
		end
	end

	initial begin
		int model_pc;
		int count;
		logic [31:0] inst;
		logic [31:0] r;
		logic [xlen-1:0] exp_value;
		clk = 1'b0;
		rst = 1'b1;
		run = 1'b0;
		mem_we = 1'b0;
		mem_waddr = '0;
		mem_wdata = '0;
		retire_ready = 1'b0;
		rng_state = 32'h7748;
		for (int k = 0; k < 32; k++) begin
			mregs[k] = '0;
		end
		// first eight addi give x0..x7 a defined start value
		for (int k = 0; k < n_inst; k++) begin
			if (k < 8) begin
				r = draw_random();
				prog[k] = {r[11:0], 5'd0, f3_add, 5'(k), opcode_op_imm};
			end else begin
				prog[k] = build_inst();
			end
		end
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		// two instructions per line with the upper word at pc bit 2
		for (int k = 0; k < mem_words; k++) begin
			mem_we = 1'b1;
			mem_waddr = mem_addr_w'(k);
			mem_wdata = {prog[2*k+1], prog[2*k]};
			@(posedge clk);
			#1;
		end
		mem_we = 1'b0;
		run = 1'b1;
		model_pc = 0;
		count = 0;
		while (count < n_retire) begin
			@(posedge clk);
			#1;
			// ready low about a quarter of the time
			r = draw_random();
			retire_ready = r[1:0] != 2'b00;
			// outputs settled here and the transfer lands on the next edge
			if (retire_valid && retire_ready) begin
				inst = prog[model_pc / 4];
				exp_value = model_result(inst);
				check_tag(retire_pc, pc_w'(model_pc), retire_rd, inst[11:7]);
				check_value("retire_value", retire_value, exp_value);
				if (inst[11:7] != 5'd0) begin
					mregs[inst[11:7]] = exp_value;
				end
				model_pc = (model_pc + 4) % 1024;
				count++;
			end
		end
		$display("Everything OK");
		$finish;
	end

endmodule

// ==== source/core_top.sv ====
module core_top import rv_pkg::*; (
	input logic clk,
	input logic rst,
	input logic run,
	input logic mem_we,
	input logic [mem_addr_w-1:0] mem_waddr,
	input logic [xlen-1:0] mem_wdata,
	output logic retire_valid,
	output logic [pc_w-1:0] retire_pc,
	output logic [reg_addr_w-1:0] retire_rd,
	output logic [xlen-1:0] retire_value,
	input logic retire_ready
);

	// sram read channels
	logic arvalid;
	logic arready;
	logic [mem_addr_w-1:0] araddr;
	logic rvalid;
	logic rready;
	logic [xlen-1:0] rdata;
	logic rresp;

	// fetch to decode
	logic if_valid;
	logic if_ready;
	inst_word_u if_inst;
	logic [pc_w-1:0] if_pc;

	// register file reads and writeback sideband
	logic [reg_addr_w-1:0] rs1_addr;
	logic [reg_addr_w-1:0] rs2_addr;
	logic [xlen-1:0] rs1_data;
	logic [xlen-1:0] rs2_data;
	logic wb_en;
	logic [reg_addr_w-1:0] wb_rd;

	// decode to execute
	logic id_valid;
	logic id_ready;
	alu_op_e id_op;
	logic [xlen-1:0] id_a;
	logic [xlen-1:0] id_b;
	logic [reg_addr_w-1:0] id_rd;
	logic [pc_w-1:0] id_pc;

	// execute to result
	logic ex_valid;
	logic ex_ready;
	logic [xlen-1:0] ex_value;
	logic [reg_addr_w-1:0] ex_rd;
	logic [pc_w-1:0] ex_pc;

	inst_sram inst_sram_i (
		.clk, .rst, .mem_we, .mem_waddr, .mem_wdata,
		.arvalid, .araddr, .arready,
		.rvalid, .rdata, .rresp, .rready
	);

	inst_fetch inst_fetch_i (
		.clk, .rst, .run,
		.arvalid, .araddr, .arready,
		.rvalid, .rdata, .rresp, .rready,
		.if_valid, .if_inst, .if_pc, .if_ready
	);

	inst_decode inst_decode_i (
		.clk, .rst,
		.if_valid, .if_inst, .if_pc, .if_ready,
		.rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
		.wb_en, .wb_rd,
		.id_valid, .id_op, .id_a, .id_b, .id_rd, .id_pc, .id_ready
	);

	alu_execute alu_execute_i (
		.clk, .rst,
		.id_valid, .id_op, .id_a, .id_b, .id_rd, .id_pc, .id_ready,
		.ex_valid, .ex_value, .ex_rd, .ex_pc, .ex_ready
	);

	// write data stays inside result, decode only needs the index
	writeback_result writeback_result_i (
		.clk, .rst,
		.ex_valid, .ex_value, .ex_rd, .ex_pc, .ex_ready,
		.rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
		.wb_en, .wb_rd, .wb_value(),
		.retire_valid, .retire_pc, .retire_rd, .retire_value, .retire_ready
	);

endmodule

// ==== source/writeback_result.sv ====
module writeback_result import rv_pkg::*; (
	input logic clk,
	input logic rst,
	input logic ex_valid,
	input logic [xlen-1:0] ex_value,
	input logic [reg_addr_w-1:0] ex_rd,
	input logic [pc_w-1:0] ex_pc,
	output logic ex_ready,
	input logic [reg_addr_w-1:0] rs1_addr,
	input logic [reg_addr_w-1:0] rs2_addr,
	output logic [xlen-1:0] rs1_data,
	output logic [xlen-1:0] rs2_data,
	output logic wb_en,
	output logic [reg_addr_w-1:0] wb_rd,
	output logic [xlen-1:0] wb_value,
	output logic retire_valid,
	output logic [pc_w-1:0] retire_pc,
	output logic [reg_addr_w-1:0] retire_rd,
	output logic [xlen-1:0] retire_value,
	input logic retire_ready
);

	// x1..x31, x0 is not stored
	logic [xlen-1:0] regs [1:31];

	// retire slot empty or draining
	assign ex_ready = !retire_valid || retire_ready;

	// write and scoreboard clear on the accept edge
	assign wb_en = ex_valid && ex_ready;
	assign wb_rd = ex_rd;
	assign wb_value = ex_value;

	// scoreboard keeps reads behind writes, no bypass
	assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

	always_ff @(posedge clk) begin
		// writes to x0 vanish
		if (wb_en && wb_rd != '0) begin
			regs[wb_rd] <= wb_value;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			retire_valid <= 1'b0;
		end else if (wb_en) begin
			retire_valid <= 1'b1;
		end else if (retire_ready) begin
			retire_valid <= 1'b0;
		end
	end

	// x0 records still carry the computed value
	always_ff @(posedge clk) begin
		if (wb_en) begin
			retire_pc <= ex_pc;
			retire_rd <= ex_rd;
			retire_value <= ex_value;
		end
	end

endmodule

// ==== source/alu_execute.sv ====
module alu_execute import rv_pkg::*; (
	input logic clk,
	input logic rst,
	input logic id_valid,
	input alu_op_e id_op,
	input logic [xlen-1:0] id_a,
	input logic [xlen-1:0] id_b,
	input logic [reg_addr_w-1:0] id_rd,
	input logic [pc_w-1:0] id_pc,
	output logic id_ready,
	output logic ex_valid,
	output logic [xlen-1:0] ex_value,
	output logic [reg_addr_w-1:0] ex_rd,
	output logic [pc_w-1:0] ex_pc,
	input logic ex_ready
);

	logic [shamt_w-1:0] shamt;
	logic [xlen-1:0] result;

	// rv64 shifts look at six bits only
	assign shamt = id_b[shamt_w-1:0];

	always_comb begin
		case (id_op)
			add: result = id_a + id_b;
			sub: result = id_a - id_b;
			slt: result = {{(xlen-1){1'b0}}, $signed(id_a) < $signed(id_b)};
			sltu: result = {{(xlen-1){1'b0}}, id_a < id_b};
			and_op: result = id_a & id_b;
			or_op: result = id_a | id_b;
			xor_op: result = id_a ^ id_b;
			sll: result = id_a << shamt;
			srl: result = id_a >> shamt;
			sra: result = xlen'($signed(id_a) >>> shamt);
			default: result = id_a + id_b;
		endcase
	end

	// accept while empty or while the held result leaves
	assign id_ready = !ex_valid || ex_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_valid <= 1'b0;
		end else if (id_valid && id_ready) begin
			ex_valid <= 1'b1;
		end else if (ex_ready) begin
			ex_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (id_valid && id_ready) begin
			ex_value <= result;
			ex_rd <= id_rd;
			ex_pc <= id_pc;
		end
	end

	// decode holds its issued operation steady while this stage stalls
	a_in_stable: assert property (@(posedge clk) disable iff (rst)
		(id_valid && !id_ready) |=>
		(id_valid && $stable(id_op) && $stable(id_a) && $stable(id_b)
		&& $stable(id_rd) && $stable(id_pc)));

endmodule

// ==== source/inst_decode.sv ====
module inst_decode import rv_pkg::*; (
	input logic clk,
	input logic rst,
	input logic if_valid,
	input inst_word_u if_inst,
	input logic [pc_w-1:0] if_pc,
	output logic if_ready,
	output logic [reg_addr_w-1:0] rs1_addr,
	output logic [reg_addr_w-1:0] rs2_addr,
	input logic [xlen-1:0] rs1_data,
	input logic [xlen-1:0] rs2_data,
	input logic wb_en,
	input logic [reg_addr_w-1:0] wb_rd,
	output logic id_valid,
	output alu_op_e id_op,
	output logic [xlen-1:0] id_a,
	output logic [xlen-1:0] id_b,
	output logic [reg_addr_w-1:0] id_rd,
	output logic [pc_w-1:0] id_pc,
	input logic id_ready
);

	logic is_op;
	logic is_imm;
	logic is_shift;
	logic alt;
	alu_op_e op;
	logic [xlen-1:0] opnd_b;
	logic [reg_addr_w-1:0] rd;
	logic [(1 << reg_addr_w)-1:0] busy;
	logic [(1 << reg_addr_w)-1:0] busy_next;
	logic hazard;
	logic issue;

	assign is_op = if_inst.r.opcode == opcode_op;
	assign is_imm = if_inst.i.opcode == opcode_op_imm;
	assign is_shift = if_inst.r.funct3 == f3_sll || if_inst.r.funct3 == f3_sr;
	// funct7 bit 5 doubles as imm12[10] for srai
	assign alt = if_inst.r.funct7[f7_alt];

	// register file read is combinational in result stage
	assign rs1_addr = if_inst.r.rs1;
	assign rs2_addr = if_inst.r.rs2;

	// unknown opcodes retire as a write to x0
	assign rd = (is_op || is_imm) ? if_inst.r.rd : '0;

	always_comb begin
		case (if_inst.r.funct3)
			// addi has no sub form
			f3_add: op = (is_op && alt) ? sub : add;
			f3_sll: op = sll;
			f3_slt: op = slt;
			f3_sltu: op = sltu;
			f3_xor: op = xor_op;
			f3_sr: op = alt ? sra : srl;
			f3_or: op = or_op;
			f3_and: op = and_op;
			default: op = add;
		endcase
		if (!(is_op || is_imm)) begin
			op = add;
		end
	end

	// second operand is rs2, shamt or sign-extended imm12
	always_comb begin
		if (is_op) begin
			opnd_b = rs2_data;
		end else if (is_shift) begin
			opnd_b = {{(xlen-shamt_w){1'b0}}, if_inst.i.imm12[shamt_w-1:0]};
		end else begin
			opnd_b = {{(xlen-12){if_inst.i.imm12[11]}}, if_inst.i.imm12};
		end
	end

	// stall while a source or rd still waits for writeback
	assign hazard = ((is_op || is_imm) && busy[rs1_addr]) || (is_op && busy[rs2_addr])
		|| busy[rd];
	assign if_ready = !hazard && (!id_valid || id_ready);
	assign issue = if_valid && if_ready;

	// clear first so that a same-edge set wins
	always_comb begin
		busy_next = busy;
		if (wb_en) begin
			busy_next[wb_rd] = 1'b0;
		end
		if (issue && rd != '0) begin
			busy_next[rd] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= '0;
			id_valid <= 1'b0;
		end else begin
			busy <= busy_next;
			if (issue) begin
				id_valid <= 1'b1;
			end else if (id_ready) begin
				id_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			id_op <= op;
			id_a <= rs1_data;
			id_b <= opnd_b;
			id_rd <= rd;
			id_pc <= if_pc;
		end
	end

endmodule

// ==== source/inst_fetch.sv ====
module inst_fetch import rv_pkg::*; (
	input logic clk,
	input logic rst,
	input logic run,
	output logic arvalid,
	output logic [mem_addr_w-1:0] araddr,
	input logic arready,
	input logic rvalid,
	input logic [xlen-1:0] rdata,
	input logic rresp,
	output logic rready,
	output logic if_valid,
	output inst_word_u if_inst,
	output logic [pc_w-1:0] if_pc,
	input logic if_ready
);

	logic [pc_w-1:0] pc;
	// pc of the read in flight
	logic [pc_w-1:0] req_pc;
	logic rd_pending;
	logic [inst_w-1:0] half;

	// one read at a time, and only with an empty buffer
	assign arvalid = run && !rd_pending && !if_valid;
	// drop the byte offset, sram is line addressed
	assign araddr = pc[pc_w-1:3];
	// take the response when the buffer is free or draining
	assign rready = !if_valid || if_ready;

	// pc bit 2 picks the upper word
	assign half = req_pc[2] ? rdata[2*inst_w-1:inst_w] : rdata[inst_w-1:0];

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			rd_pending <= 1'b0;
		end else if (arvalid && arready) begin
			// wraps at the top of the 1 KiB space
			pc <= pc + pc_w'(4);
			rd_pending <= 1'b1;
		end else if (rvalid && rready) begin
			rd_pending <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (arvalid && arready) begin
			req_pc <= pc;
		end
	end

	// one-entry instruction buffer towards decode
	always_ff @(posedge clk) begin
		if (rst) begin
			if_valid <= 1'b0;
		end else if (rvalid && rready) begin
			if_valid <= 1'b1;
		end else if (if_ready) begin
			if_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rvalid && rready) begin
			if_inst <= inst_word_u'(half);
			if_pc <= req_pc;
		end
	end

	// sram has no error path
	a_rresp_ok: assert property (@(posedge clk) disable iff (rst)
		rvalid |-> rresp);

	// a response only ever answers our own request
	a_no_stray_resp: assert property (@(posedge clk) disable iff (rst)
		rvalid |-> rd_pending);

endmodule

// ==== source/inst_sram.sv ====
module inst_sram import rv_pkg::*; (
	input logic clk,
	input logic rst,
	input logic mem_we,
	input logic [mem_addr_w-1:0] mem_waddr,
	input logic [xlen-1:0] mem_wdata,
	input logic arvalid,
	input logic [mem_addr_w-1:0] araddr,
	output logic arready,
	output logic rvalid,
	output logic [xlen-1:0] rdata,
	output logic rresp,
	input logic rready
);

	logic [xlen-1:0] mem [mem_words];

	// new address only once the held response has gone
	assign arready = !rvalid;

	// load port, testbench fills the array before run
	always_ff @(posedge clk) begin
		if (mem_we) begin
			mem[mem_waddr] <= mem_wdata;
		end
	end

	// read data registered, held until rready
	always_ff @(posedge clk) begin
		if (arvalid && arready) begin
			rdata <= mem[araddr];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rvalid <= 1'b0;
			rresp <= 1'b0;
		end else if (arvalid && arready) begin
			rvalid <= 1'b1;
			// no error source, always okay
			rresp <= 1'b1;
		end else if (rvalid && rready) begin
			rvalid <= 1'b0;
			rresp <= 1'b0;
		end
	end

	// requester must not move the line while waiting
	a_araddr_stable: assert property (@(posedge clk) disable iff (rst)
		(arvalid && !arready) |=> $stable(araddr));

endmodule

// ==== source/rv_pkg.sv ====
package rv_pkg;

	// datapath width, rv64
	localparam int xlen = 64;
	// register index, x0..x31
	localparam int reg_addr_w = 5;
	// byte address, 1 KiB program space
	localparam int pc_w = 10;
	// memory organised as 64-bit lines
	localparam int mem_words = 128;
	localparam int mem_addr_w = 7;
	// one instruction is half a line
	localparam int inst_w = 32;
	// rv64 shift amount
	localparam int shamt_w = 6;

	// major opcodes handled by this slice
	localparam logic [6:0] opcode_op = 7'b0110011;
	localparam logic [6:0] opcode_op_imm = 7'b0010011;

	// funct3 codes, shared by register and immediate forms
	localparam logic [2:0] f3_add = 3'b000;
	localparam logic [2:0] f3_sll = 3'b001;
	localparam logic [2:0] f3_slt = 3'b010;
	localparam logic [2:0] f3_sltu = 3'b011;
	localparam logic [2:0] f3_xor = 3'b100;
	localparam logic [2:0] f3_sr = 3'b101;
	localparam logic [2:0] f3_or = 3'b110;
	localparam logic [2:0] f3_and = 3'b111;

	// funct7 bit index that turns add into sub and srl into sra
	localparam int f7_alt = 5;

	// alu operation select
	typedef enum logic [3:0] {
		add,
		sub,
		slt,
		sltu,
		and_op,
		or_op,
		xor_op,
		sll,
		srl,
		sra
	} alu_op_e;

	// one instruction word, read as r-type or i-type
	// funct7 overlays imm12[11:5], so srai keeps its alt bit in the r view
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm12;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} i;
	} inst_word_u;

endpackage
